/* Bender.yml */
package:
  name: cache

sources:
  - verilog/cachePkg.sv
  - verilog/cacheStore.sv
  - verilog/cacheCtrl.sv
  - verilog/refillUnit.sv
  - verilog/cacheTop.sv
  - target: test
    files:
      - tests/cacheChecker.sv
      - tests/cacheTb.sv

/* compile.f */
verilog/cachePkg.sv
verilog/cacheStore.sv
verilog/cacheCtrl.sv
verilog/refillUnit.sv
verilog/cacheTop.sv
tests/cacheChecker.sv
tests/cacheTb.sv

/* tests/cacheChecker.sv */
module cacheChecker import cachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [2:0]           testId_i,
  input  logic                 reqValid_i,
  input  cpuReq_t              req_i,
  input  logic                 reqReady_i,
  input  logic                 dataOk_i,
  input  cpuResp_t             resp_i,
  input  logic                 memReq_i,
  input  logic [AddrWidth-1:0] memAddr_i,
  output int                   valueErrs_o,
  output int                   protoErrs_o,
  output int                   pending_o
);

  // reference tags, valid bits and victim pointer per set
  logic [20:0] refTag [2][64];
  logic [1:0]  refValid [64];
  logic        refLru [64];

  // outstanding requests in arrival order
  logic [31:0] pendAddr [$];
  bit          pendHit [$];
  int          pendCyc [$];

  bit          headMemSeen;
  bit          predHit;
  logic [31:0] headAddr;
  int          cycle;
  int          valueErrs;
  int          protoErrs;

  assign valueErrs_o = valueErrs;
  assign protoErrs_o = protoErrs;

  // memory holds {A, ~A} for the 8-byte word at A
  function automatic logic [63:0] expectedWord(input logic [31:0] addr);
    logic [31:0] aligned;
    aligned = {addr[31:3], 3'b000};
    return {aligned, ~aligned};
  endfunction

  function automatic string testName(input logic [2:0] id);
    case (id)
      3'd1:    return "coldMiss";
      3'd2:    return "hitRepeat";
      3'd3:    return "lruOrder";
      3'd4:    return "randomMix";
      default: return "reset";
    endcase
  endfunction

  // the lru way is the victim and each use points lru at the other way
  task automatic refAccess(input logic [31:0] addr, output bit hit);
    logic [20:0] tag;
    logic [5:0]  idx;
    int          way;
    tag = addr[31:11];
    idx = addr[10:5];
    hit = 1'b0;
    way = refLru[idx];
    for (int w = 0; w < 2; w++) begin
      if (refValid[idx][w] && (refTag[w][idx] == tag)) begin
        hit = 1'b1;
        way = w;
      end
    end
    if (!hit) begin
      refTag[way][idx]   = tag;
      refValid[idx][way] = 1'b1;
    end
    refLru[idx] = (way == 0);
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (!rst_n) begin
      if (!reqReady_i || dataOk_i || memReq_i) begin
        protoErrs++;
        $display("outputs wrong in reset: ready %b dataOk %b memReq %b",
                 reqReady_i, dataOk_i, memReq_i);
      end
      for (int s = 0; s < 64; s++) begin
        refValid[s] = 2'b00;
        refLru[s]   = 1'b0;
      end
    end else begin
      if (memReq_i) begin
        if (pendAddr.size() == 0 || pendHit[0] || cycle != pendCyc[0] + 2) begin
          protoErrs++;
          $display("unexpected memReq_o at cycle %0d", cycle);
        end else begin
          headMemSeen = 1'b1;
          if (memAddr_i !== {pendAddr[0][31:5], 5'b00000}) begin
            valueErrs++;
            $display("ERR %s memAddr expected %h actual %h", testName(testId_i),
                     {pendAddr[0][31:5], 5'b00000}, memAddr_i);
          end
        end
      end else if (pendAddr.size() != 0 && !pendHit[0] && !headMemSeen &&
                   cycle == pendCyc[0] + 2) begin
        protoErrs++;
        $display("miss to %h gave no memReq_o", pendAddr[0]);
      end
      // a miss holds reqReady_o low from its compare until its reply
      if (pendAddr.size() != 0 && !pendHit[0] && cycle > pendCyc[0] &&
          !dataOk_i && reqReady_i !== 1'b0) begin
        protoErrs++;
        $display("reqReady_o high during the miss to %h at cycle %0d",
                 pendAddr[0], cycle);
      end
      if (dataOk_i) begin
        if (pendAddr.size() == 0) begin
          protoErrs++;
          $display("dataOk_o with no request outstanding at cycle %0d", cycle);
        end else begin
          if (pendHit[0] && cycle != pendCyc[0] + 2) begin
            protoErrs++;
            $display("hit to %h replied %0d cycles after the strobe",
                     pendAddr[0], cycle - pendCyc[0]);
          end
          if (!pendHit[0] && !headMemSeen) begin
            protoErrs++;
            $display("miss to %h replied without a memory request", pendAddr[0]);
          end
          headAddr = pendAddr.pop_front();
          void'(pendHit.pop_front());
          void'(pendCyc.pop_front());
          headMemSeen = 1'b0;
          if (resp_i.data !== expectedWord(headAddr)) begin
            valueErrs++;
            $display("ERR %s data expected %h actual %h", testName(testId_i),
                     expectedWord(headAddr), resp_i.data);
          end
        end
      end
      if (pendAddr.size() != 0 && pendHit[0] && cycle > pendCyc[0] + 2) begin
        protoErrs++;
        $display("missing reply for hit to %h", pendAddr[0]);
        void'(pendAddr.pop_front());
        void'(pendHit.pop_front());
        void'(pendCyc.pop_front());
      end
      if (reqValid_i) begin
        if (!reqReady_i) begin
          protoErrs++;
          $display("request strobed while reqReady_o was low at cycle %0d", cycle);
        end
        refAccess(req_i.addr.raw, predHit);
        pendAddr.push_back(req_i.addr.raw);
        pendHit.push_back(predHit);
        pendCyc.push_back(cycle);
      end
    end
    pending_o = pendAddr.size();
  end

endmodule

/* tests/cacheTb.sv */
module cacheTb import cachePkg::*; ();

  localparam int NumRandom       = 200;
  localparam int NumRequests     = 12 + NumRandom;
  // compare, request, 6 latency, 4 beats, fill and reply with slack
  localparam int WorstMissCycles = 20;
  localparam int TimeoutTime     = (NumRequests * WorstMissCycles + 100) * 10;

  logic                 clk;
  logic                 rst_n;
  logic                 reqValid;
  cpuReq_t              req;
  logic                 reqReady;
  logic                 dataOk;
  cpuResp_t             resp;
  logic                 memReq;
  logic [AddrWidth-1:0] memAddr;
  logic                 memBeatValid;
  logic [XLen-1:0]      memBeat;
  logic                 memLast;
  logic [2:0]           testId;
  int                   valueErrs;
  int                   protoErrs;
  int                   pending;
  int                   sent;
  int                   replies;
  int                   seedInit;

  cacheTop dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .reqValid_i     (reqValid),
    .req_i          (req),
    .reqReady_o     (reqReady),
    .dataOk_o       (dataOk),
    .resp_o         (resp),
    .memReq_o       (memReq),
    .memAddr_o      (memAddr),
    .memBeatValid_i (memBeatValid),
    .memBeat_i      (memBeat),
    .memLast_i      (memLast)
  );

  cacheChecker chk (
    .clk         (clk),
    .rst_n       (rst_n),
    .testId_i    (testId),
    .reqValid_i  (reqValid),
    .req_i       (req),
    .reqReady_i  (reqReady),
    .dataOk_i    (dataOk),
    .resp_i      (resp),
    .memReq_i    (memReq),
    .memAddr_i   (memAddr),
    .valueErrs_o (valueErrs),
    .protoErrs_o (protoErrs),
    .pending_o   (pending)
  );

  always #5 clk = ~clk;

  // replies counted mid-cycle where dataOk is stable
  always @(negedge clk) begin
    if (dataOk) begin
      replies++;
    end
  end

  function automatic logic [31:0] buildAddr(input logic [20:0] tag, input logic [5:0] idx,
                                            input logic [1:0] word, input logic [2:0] byteOff);
    return {tag, idx, word, byteOff};
  endfunction

  function automatic logic [63:0] memWord(input logic [31:0] a);
    return {a, ~a};
  endfunction

  task automatic issueReq(input logic [31:0] addr);
    @(posedge clk);
    reqValid      <= 1'b1;
    req.addr.raw  <= addr;
    sent++;
  endtask

  task automatic closeStrobe();
    @(posedge clk);
    reqValid <= 1'b0;
  endtask

  task automatic waitReplies();
    while (replies < sent) begin
      @(posedge clk);
    end
  endtask

  task automatic singleAccess(input logic [31:0] addr);
    issueReq(addr);
    closeStrobe();
    waitReplies();
  endtask

  // burst memory with random latency of 1 to 6 cycles
  initial begin : memoryModel
    int                   latency;
    logic [AddrWidth-1:0] lineBase;
    forever begin
      @(posedge clk);
      if (rst_n && memReq) begin
        lineBase = memAddr;
        latency  = 1 + ($urandom % 6);
        repeat (latency - 1) @(posedge clk);
        for (int b = 0; b < BeatsPerLine; b++) begin
          memBeatValid <= 1'b1;
          memBeat      <= memWord(lineBase + 32'(b * 8));
          memLast      <= (b == BeatsPerLine - 1);
          @(posedge clk);
        end
        memBeatValid <= 1'b0;
        memLast      <= 1'b0;
      end
    end
  end

  initial begin : watchdog
    #(TimeoutTime);
    $display("timeout: the cache stopped answering requests");
    $display("*** FAILED ***");
    $finish;
  end

  initial begin
    seedInit     = $urandom(89);
    clk          = 1'b0;
    rst_n        = 1'b0;
    reqValid     = 1'b0;
    req          = '0;
    memBeatValid = 1'b0;
    memBeat      = '0;
    memLast      = 1'b0;
    testId       = 3'd0;
    sent         = 0;
    replies      = 0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    testId <= 3'd1;
    singleAccess(buildAddr(21'h00123, 6'd5, 2'd2, 3'd0));

    // one repeat, then four back-to-back hits over the line
    testId <= 3'd2;
    singleAccess(buildAddr(21'h00123, 6'd5, 2'd0, 3'd4));
    for (int w = 0; w < 4; w++) begin
      issueReq(buildAddr(21'h00123, 6'd5, 2'(w), 3'd0));
    end
    closeStrobe();
    waitReplies();

    // A B A C leaves B as the victim
    testId <= 3'd3;
    singleAccess(buildAddr(21'h000AA, 6'd9, 2'd0, 3'd0));
    singleAccess(buildAddr(21'h000BB, 6'd9, 2'd1, 3'd0));
    singleAccess(buildAddr(21'h000AA, 6'd9, 2'd2, 3'd0));
    singleAccess(buildAddr(21'h000CC, 6'd9, 2'd3, 3'd0));
    singleAccess(buildAddr(21'h000AA, 6'd9, 2'd1, 3'd0));
    singleAccess(buildAddr(21'h000BB, 6'd9, 2'd0, 3'd0));

    testId <= 3'd4;
    for (int i = 0; i < NumRandom; i++) begin
      singleAccess(buildAddr(21'h0A000 + 21'($urandom % 4), 6'($urandom % 4),
                             2'($urandom % 4), 3'($urandom % 8)));
    end

    repeat (3) @(posedge clk);
    $display("errors: value %0d, protocol %0d, unanswered %0d", valueErrs, protoErrs, pending);
    if (valueErrs == 0 && protoErrs == 0 && pending == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog/cacheCtrl.sv */
module cacheCtrl import cachePkg::*; (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     reqValid_i,
  input  cpuReq_t                  req_i,
  output logic                     reqReady_o,
  output logic                     dataOk_o,
  output cpuResp_t                 resp_o,
  output logic                     rdEn_o,
  output logic [IndexBits-1:0]     rdIndex_o,
  input  logic [1:0][TagBits-1:0]  tags_i,
  input  logic [1:0]               valids_i,
  input  logic [1:0][LineBits-1:0] lines_i,
  input  logic                     lru_i,
  output logic                     touchValid_o,
  output lruTouch_t                touch_o,
  output logic                     refillStart_o,
  output refillReq_t               refill_o,
  input  logic                     fillValid_i,
  input  lineFill_t                fill_i
);

  typedef enum logic [1:0] {
    Idle,
    Compare,
    Refill,
    Reply
  } state_e;

  state_e state;
  state_e stateNext;

  cpuReq_t             reqQ;
  logic [1:0]          hitWay;
  logic                cacheHit;
  logic [LineBits-1:0] hitLine;
  logic                replyNow;
  logic [XLen-1:0]     replyWord;

  function automatic logic [XLen-1:0] pickWord(
    input logic [LineBits-1:0]             line,
    input logic [$clog2(BeatsPerLine)-1:0] sel
  );
    return line[sel*XLen +: XLen];
  endfunction

  // accept in idle, reply, or while a hit retires
  assign reqReady_o = (state == Idle) || (state == Reply) ||
                      ((state == Compare) && cacheHit);
  assign rdEn_o     = reqValid_i && reqReady_o;
  assign rdIndex_o  = req_i.addr.f.index;

  always_ff @(posedge clk) begin
    if (rdEn_o) begin
      reqQ <= req_i;
    end
  end

  // two-way tag compare
  always_comb begin
    for (int w = 0; w < 2; w++) begin
      hitWay[w] = valids_i[w] && (tags_i[w] == reqQ.addr.f.tag);
    end
  end

  assign cacheHit = |hitWay;
  assign hitLine  = hitWay[1] ? lines_i[1] : lines_i[0];

  always_comb begin
    stateNext = state;
    case (state)
      Idle, Reply: begin
        stateNext = reqValid_i ? Compare : Idle;
      end
      Compare: begin
        if (!cacheHit) begin
          stateNext = Refill;
        end else begin
          stateNext = reqValid_i ? Compare : Idle;
        end
      end
      Refill: begin
        if (fillValid_i) begin
          stateNext = Reply;
        end
      end
      default: stateNext = Idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= Idle;
    end else begin
      state <= stateNext;
    end
  end

  assign touchValid_o  = (state == Compare) && cacheHit;
  assign touch_o.index = reqQ.addr.f.index;
  assign touch_o.way   = hitWay[1];

  // miss goes to the lru victim
  assign refillStart_o  = (state == Compare) && !cacheHit;
  assign refill_o.tag   = reqQ.addr.f.tag;
  assign refill_o.index = reqQ.addr.f.index;
  assign refill_o.way   = lru_i;

  assign replyNow  = touchValid_o || ((state == Refill) && fillValid_i);
  assign replyWord = (state == Refill) ? pickWord(fill_i.line, reqQ.addr.f.wordSel)
                                       : pickWord(hitLine, reqQ.addr.f.wordSel);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dataOk_o <= 1'b0;
    end else begin
      dataOk_o <= replyNow;
    end
  end

  always_ff @(posedge clk) begin
    if (replyNow) begin
      resp_o.data <= replyWord;
    end
  end

  reqOnlyWhenReady: assert property (
    @(posedge clk) disable iff (!rst_n) reqValid_i |-> reqReady_o
  );

  // the store never keeps one tag in both ways of a set
  noDoubleHit: assert property (
    @(posedge clk) disable iff (!rst_n) (state == Compare) |-> !(&hitWay)
  );

endmodule

/* verilog/cachePkg.sv */
package cachePkg;

  // geometry
  localparam int AddrWidth    = 32;
  localparam int XLen         = 64;
  localparam int OffsetBits   = 5;
  localparam int IndexBits    = 6;
  localparam int TagBits      = 21;
  localparam int Sets         = 64;
  localparam int LineBits     = 256;
  localparam int BeatsPerLine = 4;

  // lookup view of a byte address
  typedef struct packed {
    logic [TagBits-1:0]              tag;
    logic [IndexBits-1:0]            index;
    logic [$clog2(BeatsPerLine)-1:0] wordSel;
    logic [$clog2(XLen/8)-1:0]       byteOff;
  } addrFields_t;

  // raw for the memory side, split for the lookup
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    addrFields_t          f;
  } cacheAddr_u;

  typedef struct packed {
    cacheAddr_u addr;
  } cpuReq_t;

  typedef struct packed {
    logic [XLen-1:0] data;
  } cpuResp_t;

  typedef struct packed {
    logic [TagBits-1:0]   tag;
    logic [IndexBits-1:0] index;
    logic                 way;
  } refillReq_t;

  typedef struct packed {
    logic [IndexBits-1:0] index;
    logic                 way;
    logic [TagBits-1:0]   tag;
    logic [LineBits-1:0]  line;
  } lineFill_t;

  typedef struct packed {
    logic [IndexBits-1:0] index;
    logic                 way;
  } lruTouch_t;

endpackage

/* verilog/cacheStore.sv */
module cacheStore import cachePkg::*; (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            rdEn_i,
  input  logic [IndexBits-1:0]            rdIndex_i,
  input  logic                            touchValid_i,
  input  lruTouch_t                       touch_i,
  input  logic                            fillValid_i,
  input  lineFill_t                       fill_i,
  output logic [1:0][TagBits-1:0]         tags_o,
  output logic [1:0]                      valids_o,
  output logic [1:0][LineBits-1:0]        lines_o,
  output logic                            lru_o
);

  // two ways of tag and line storage
  logic [TagBits-1:0]  tagMem  [2][Sets];
  logic [LineBits-1:0] dataMem [2][Sets];

  // per-way valid bits, lru points at the victim way
  logic [1:0][Sets-1:0] validQ;
  logic [Sets-1:0]      lruQ;

  logic fillHit;
  logic touchHit;

  assign fillHit  = fillValid_i && (fill_i.index == rdIndex_i);
  assign touchHit = touchValid_i && (touch_i.index == rdIndex_i);

  always_ff @(posedge clk) begin
    if (fillValid_i) begin
      tagMem[fill_i.way][fill_i.index]  <= fill_i.tag;
      dataMem[fill_i.way][fill_i.index] <= fill_i.line;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validQ <= '0;
      lruQ   <= '0;
    end else begin
      if (fillValid_i) begin
        validQ[fill_i.way][fill_i.index] <= 1'b1;
        lruQ[fill_i.index]               <= ~fill_i.way;
      end
      // a hit makes the other way the victim
      if (touchValid_i) begin
        lruQ[touch_i.index] <= ~touch_i.way;
      end
    end
  end

  // synchronous read, same-cycle fill forwarded
  always_ff @(posedge clk) begin
    if (rdEn_i) begin
      for (int w = 0; w < 2; w++) begin
        if (fillHit && (fill_i.way == 1'(w))) begin
          tags_o[w]  <= fill_i.tag;
          lines_o[w] <= fill_i.line;
        end else begin
          tags_o[w]  <= tagMem[w][rdIndex_i];
          lines_o[w] <= dataMem[w][rdIndex_i];
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valids_o <= '0;
      lru_o    <= 1'b0;
    end else if (rdEn_i) begin
      for (int w = 0; w < 2; w++) begin
        valids_o[w] <= validQ[w][rdIndex_i] | (fillHit && (fill_i.way == 1'(w)));
      end
      // newest lru update wins
      if (fillHit) begin
        lru_o <= ~fill_i.way;
      end else if (touchHit) begin
        lru_o <= ~touch_i.way;
      end else begin
        lru_o <= lruQ[rdIndex_i];
      end
    end
  end

  // hits are only resolved while no refill is outstanding
  touchFillExclusive: assert property (
    @(posedge clk) disable iff (!rst_n) !(touchValid_i && fillValid_i)
  );

endmodule

/* verilog/cacheTop.sv */
module cacheTop import cachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  // processor fetch port
  input  logic                 reqValid_i,
  input  cpuReq_t              req_i,
  output logic                 reqReady_o,
  output logic                 dataOk_o,
  output cpuResp_t             resp_o,
  // burst memory port
  output logic                 memReq_o,
  output logic [AddrWidth-1:0] memAddr_o,
  input  logic                 memBeatValid_i,
  input  logic [XLen-1:0]      memBeat_i,
  input  logic                 memLast_i
);

  logic                     rdEn;
  logic [IndexBits-1:0]     rdIndex;
  logic [1:0][TagBits-1:0]  tags;
  logic [1:0]               valids;
  logic [1:0][LineBits-1:0] lines;
  logic                     lru;
  logic                     touchValid;
  lruTouch_t                touch;
  logic                     refillStart;
  refillReq_t               refill;
  logic                     fillValid;
  lineFill_t                fill;

  cacheCtrl uCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .reqValid_i    (reqValid_i),
    .req_i         (req_i),
    .reqReady_o    (reqReady_o),
    .dataOk_o      (dataOk_o),
    .resp_o        (resp_o),
    .rdEn_o        (rdEn),
    .rdIndex_o     (rdIndex),
    .tags_i        (tags),
    .valids_i      (valids),
    .lines_i       (lines),
    .lru_i         (lru),
    .touchValid_o  (touchValid),
    .touch_o       (touch),
    .refillStart_o (refillStart),
    .refill_o      (refill),
    .fillValid_i   (fillValid),
    .fill_i        (fill)
  );

  cacheStore uStore (
    .clk          (clk),
    .rst_n        (rst_n),
    .rdEn_i       (rdEn),
    .rdIndex_i    (rdIndex),
    .touchValid_i (touchValid),
    .touch_i      (touch),
    .fillValid_i  (fillValid),
    .fill_i       (fill),
    .tags_o       (tags),
    .valids_o     (valids),
    .lines_o      (lines),
    .lru_o        (lru)
  );

  refillUnit uRefill (
    .clk            (clk),
    .rst_n          (rst_n),
    .refillStart_i  (refillStart),
    .refill_i       (refill),
    .memReq_o       (memReq_o),
    .memAddr_o      (memAddr_o),
    .memBeatValid_i (memBeatValid_i),
    .memBeat_i      (memBeat_i),
    .memLast_i      (memLast_i),
    .fillValid_o    (fillValid),
    .fill_o         (fill)
  );

endmodule

/* verilog/refillUnit.sv */
module refillUnit import cachePkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 refillStart_i,
  input  refillReq_t           refill_i,
  output logic                 memReq_o,
  output logic [AddrWidth-1:0] memAddr_o,
  input  logic                 memBeatValid_i,
  input  logic [XLen-1:0]      memBeat_i,
  input  logic                 memLast_i,
  output logic                 fillValid_o,
  output lineFill_t            fill_o
);

  refillReq_t                              reqQ;
  cacheAddr_u                              lineAddr;
  logic [$clog2(BeatsPerLine)-1:0]         beatCnt;
  logic [BeatsPerLine-1:0][XLen-1:0]       lineBuf;

  // line-aligned address built from the field view
  always_comb begin
    lineAddr.f.tag     = refill_i.tag;
    lineAddr.f.index   = refill_i.index;
    lineAddr.f.wordSel = '0;
    lineAddr.f.byteOff = '0;
  end

  always_ff @(posedge clk) begin
    if (refillStart_i) begin
      reqQ      <= refill_i;
      memAddr_o <= lineAddr.raw;
    end
    if (memBeatValid_i) begin
      lineBuf[beatCnt] <= memBeat_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memReq_o    <= 1'b0;
      fillValid_o <= 1'b0;
      beatCnt     <= '0;
    end else begin
      memReq_o    <= refillStart_i;
      fillValid_o <= memBeatValid_i && memLast_i;
      if (refillStart_i) begin
        beatCnt <= '0;
      end else if (memBeatValid_i) begin
        beatCnt <= memLast_i ? '0 : beatCnt + 1'b1;
      end
    end
  end

  // beats land in ascending word order
  assign fill_o.index = reqQ.index;
  assign fill_o.way   = reqQ.way;
  assign fill_o.tag   = reqQ.tag;
  assign fill_o.line  = lineBuf;

  lastOnFourthBeat: assert property (
    @(posedge clk) disable iff (!rst_n)
    memBeatValid_i |-> (memLast_i == (beatCnt == BeatsPerLine - 1))
  );

endmodule
